// File: cart_loader.f
src/cart_loader_pkg.sv
src/download_decoder.sv
src/header_parser.sv
src/cheat_assembler.sv
src/ram_clearer.sv
src/cart_loader.sv
dv/cart_loader_chk.sv
dv/cart_loader_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cart_loader_tb
FLAGS     ?= --binary --timing --assert -Wno-fatal
BUILD_DIR ?= obj_dir

.PHONY: sim clean

# Pass only when the pass line shows up in the simulation output
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f cart_loader.f
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(BUILD_DIR)

// File: dv/cart_loader_tb.sv
//==============================
// Header table, one LFSR cheat code, then one full WRAM sweep per fill mode
// Each sweep runs 2^17 cycles and the run is long
//==============================

module cart_loader_tb;
	import cart_loader_pkg::*;

	typedef struct {
		string                name;
		logic [2:0]           mode;
		logic [1:0]           region;
		logic [15:0]          copier;
		logic [15:0]          word2;
		logic [3:0]           int_rom;
		logic [3:0]           int_ram;
		logic [7:0]           exp_type;
		logic [MASK_BITS-1:0] exp_rom;
		logic [MASK_BITS-1:0] exp_ram;
		logic                 exp_pal;
	} hdr_case_t;

	// Written at internal header addresses that belong to another mode
	localparam logic [15:0] DECOY = 16'h0707;
	localparam int CASES = 6;
	localparam int SWEEP = 1 << FILL_ADDR_BITS;

	hdr_case_t cases [CASES] = '{
		'{"auto_copier", HDR_AUTO, REG_AUTO, 16'h023A, 16'h0100, 4'h0, 4'h0,
			8'd2, 24'h0FFFFF, 24'h001FFF, 1'b1},
		'{"auto_default", HDR_AUTO, REG_NTSC, 16'h0300, 16'h0100, 4'h0, 4'h0,
			8'd3, 24'h3FFFFF, 24'h000000, 1'b0},
		'{"lorom", HDR_LOROM, REG_PAL, 16'h023A, 16'h0000, 4'h8, 4'h1,
			8'd0, 24'h03FFFF, 24'h0007FF, 1'b1},
		'{"hirom", HDR_HIROM, REG_AUTO, 16'h0000, 16'h0000, 4'hB, 4'h5,
			8'd1, 24'h1FFFFF, 24'h007FFF, 1'b0},
		'{"exhirom", HDR_EXHIROM, 2'd3, 16'h0000, 16'h0100, 4'h9, 4'h3,
			8'd2, 24'h07FFFF, 24'h001FFF, 1'b1},
		'{"none", HDR_NONE, REG_AUTO, 16'h023A, 16'h0100, 4'h0, 4'h0,
			8'd0, 24'h3FFFFF, 24'h000000, 1'b1}
	};

	logic clk_sys, RESET, ioctl_download, ioctl_wr;
	logic [7:0] ioctl_index;
	logic [IO_ADDR_BITS-1:0] ioctl_addr;
	logic [IO_DATA_BITS-1:0] ioctl_dout;
	logic [2:0] hdr_mode;
	logic [1:0] region_sel, wram_init;
	logic [7:0] rom_type, fill_data;
	logic [MASK_BITS-1:0] rom_mask, ram_mask;
	logic pal, code_valid, fill_wr, clearing;
	logic [CODE_BITS-1:0] code, code_seen;
	logic [FILL_ADDR_BITS-1:0] fill_addr;
	logic [31:0] lfsr = 32'h2c31;
	// ROM region bit of the last image, 0 out of reset
	logic last_rom_region = 1'b0;
	int value_errors = 0;
	int timeouts = 0;
	int valid_count = 0;

	cart_loader UUT (.*);

	always #5 clk_sys = ~clk_sys;

	// Sampled mid-cycle away from both edges
	always @(negedge clk_sys) begin
		if (code_valid) begin
			valid_count++;
			code_seen = code;
		end
	end

	task automatic step_cycles(input int n);
		repeat (n) @(posedge clk_sys);
		#1;
	endtask

	task automatic host_write(input logic [IO_ADDR_BITS-1:0] addr,
	                          input logic [IO_DATA_BITS-1:0] data);
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr = 1'b1;
		step_cycles(1);
		ioctl_wr = 1'b0;
	endtask

	task automatic check_value(input string name, input logic [CODE_BITS-1:0] exp,
	                           input logic [CODE_BITS-1:0] act);
		assert (act === exp) else begin
			value_errors++;
			$display("FAILED %s expected %0h actual %0h", name, exp, act);
		end
	endtask

	// Fibonacci taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [7:0] fill_pattern(input logic [1:0] mode,
	                                            input logic [FILL_ADDR_BITS-1:0] a);
		case (mode)
			2'd0:    return (a[8] ^ a[2]) ? 8'h66 : 8'h99;
			2'd1:    return (a[9] ^ a[0]) ? 8'hFF : 8'h00;
			2'd2:    return 8'h55;
			default: return 8'hFF;
		endcase
	endfunction

	task automatic apply_header_case(input hdr_case_t c);
		logic [IO_ADDR_BITS-1:0] hdr_addr [3];
		logic [IO_ADDR_BITS-1:0] own;
		header_word_u size_w;
		header_word_u ram_w;
		logic pal_hold;
		hdr_addr = '{LOROM_HDR, HIROM_HDR, EXHIROM_HDR};
		case (c.mode)
			HDR_LOROM:   own = LOROM_HDR;
			HDR_HIROM:   own = HIROM_HDR;
			HDR_EXHIROM: own = EXHIROM_HDR;
			default:     own = '1;
		endcase
		size_w = '0;
		size_w.internal.rom_size = c.int_rom;
		ram_w = '0;
		ram_w.internal.ram_size = c.int_ram;
		hdr_mode = c.mode;
		region_sel = c.region;
		// The previous image's region stays in effect until this download ends
		pal_hold = (c.region == REG_AUTO) ? last_rom_region : c.region[1];
		ioctl_index = 8'h00;
		ioctl_download = 1'b1;
		host_write('0, c.copier);
		host_write(IO_ADDR_BITS'(2), c.word2);
		for (int k = 0; k < 3; k++) begin
			if (hdr_addr[k] == own) begin
				host_write(own, size_w);
				host_write(own + IO_ADDR_BITS'(HDR_SIZE_OFF), ram_w);
			end else begin
				host_write(hdr_addr[k], DECOY);
				host_write(hdr_addr[k] + IO_ADDR_BITS'(HDR_SIZE_OFF), DECOY);
			end
		end
		// Parser takes the last word one cycle behind the decoder
		step_cycles(1);
		check_value({c.name, " type"}, c.exp_type, rom_type);
		check_value({c.name, " rom_mask"}, c.exp_rom, rom_mask);
		check_value({c.name, " ram_mask"}, c.exp_ram, ram_mask);
		check_value({c.name, " pal held"}, pal_hold, pal);
		ioctl_download = 1'b0;
		step_cycles(3);
		check_value({c.name, " pal"}, c.exp_pal, pal);
		last_rom_region = c.word2[8];
	endtask

	task automatic load_cheat_code();
		logic [15:0] w [8];
		logic [CODE_BITS-1:0] expected;
		int n;
		ioctl_index = IDX_CODE;
		ioctl_download = 1'b1;
		for (int k = 0; k < 8; k++) begin
			w[k] = '0;
			for (int b = 0; b < 16; b++) begin
				lfsr = lfsr_next(lfsr);
				w[k] = {w[k][14:0], lfsr[0]};
			end
			host_write(IO_ADDR_BITS'(2 * k), w[k]);
		end
		ioctl_download = 1'b0;
		// Flags on top down to replace, each high word above its low word
		expected = {w[1], w[0], w[3], w[2], w[5], w[4], w[7], w[6]};
		n = 0;
		while (valid_count == 0 && n < 10) begin
			step_cycles(1);
			n++;
		end
		if (valid_count == 0) begin
			timeouts++;
			$display("Timeout: code_valid never rose after the last cheat word");
			return;
		end
		step_cycles(4);
		check_value("cheat valid pulses", 1, valid_count);
		check_value("cheat code", expected, code_seen);
	endtask

	task automatic sweep_wram(input logic [1:0] mode);
		int n;
		logic [7:0] exp_data;
		n = 0;
		while (clearing && n < SWEEP + 16) begin
			step_cycles(1);
			n++;
		end
		if (clearing) begin
			timeouts++;
			$display("Timeout: an earlier WRAM sweep never finished");
			return;
		end
		wram_init = mode;
		ioctl_index = 8'h00;
		ioctl_download = 1'b1;
		n = 0;
		while (!fill_wr && n < 8) begin
			step_cycles(1);
			n++;
		end
		if (!fill_wr) begin
			timeouts++;
			$display("Timeout: fill_wr did not rise after the download started");
			return;
		end
		for (int a = 0; a < SWEEP; a++) begin
			exp_data = fill_pattern(mode, FILL_ADDR_BITS'(a));
			assert (fill_wr && fill_addr == FILL_ADDR_BITS'(a) &&
			        fill_data == exp_data) else begin
				value_errors++;
				$display("FAILED wram_mode_%0d expected %0h:%h actual %0h:%h wr %0b",
				         mode, a, exp_data, fill_addr, fill_data, fill_wr);
			end
			step_cycles(1);
		end
		n = 0;
		while (clearing && n < 4) begin
			step_cycles(1);
			n++;
		end
		if (clearing) begin
			timeouts++;
			$display("Timeout: clearing stayed high after the last WRAM address");
		end
		ioctl_download = 1'b0;
		step_cycles(2);
	endtask

	initial begin
		clk_sys = 1'b0;
		RESET = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_index = '0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		hdr_mode = HDR_AUTO;
		region_sel = REG_AUTO;
		wram_init = 2'd0;
		repeat (4) @(posedge clk_sys);
		#1;
		RESET = 1'b0;
		check_value("reset rom_mask", 24'h3FFFFF, rom_mask);
		check_value("reset fill_wr", 0, fill_wr);
		for (int i = 0; i < CASES; i++)
			apply_header_case(cases[i]);
		if (timeouts == 0)
			load_cheat_code();
		for (int m = 0; m < 4 && timeouts == 0; m++)
			sweep_wram(2'(m));
		$display("Errors: %0d value mismatches, %0d timeouts", value_errors, timeouts);
		if (value_errors + timeouts == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: dv/cart_loader_chk.sv
//==============================
// Cheat pulse and WRAM sweep checks bound into cart_loader
//==============================

module cart_loader_chk (
	input logic                                       clk_sys,
	input logic                                       RESET,
	input logic                                       code_valid,
	input logic                                       fill_wr,
	input logic                                       clearing,
	input logic [cart_loader_pkg::FILL_ADDR_BITS-1:0] fill_addr
);
	import cart_loader_pkg::*;

	// One cycle per completed code
	valid_pulse: assert property (@(posedge clk_sys) disable iff (RESET)
		code_valid |=> !code_valid)
		else $error("code_valid stayed high for two cycles");

	// Sweep moves up by one unless restarted at 0
	addr_step: assert property (@(posedge clk_sys) disable iff (RESET)
		(fill_wr && $past(fill_wr)) |->
		((fill_addr == FILL_ADDR_BITS'($past(fill_addr) + 1'b1)) || (fill_addr == '0)))
		else $error("fill_addr skipped during a WRAM sweep");

	// A sweep only ends after the last WRAM address
	sweep_end: assert property (@(posedge clk_sys) disable iff (RESET)
		$fell(clearing) |-> &$past(fill_addr))
		else $error("clearing fell before the last WRAM address");

endmodule

bind cart_loader cart_loader_chk u_chk (.*);

// File: src/cart_loader.sv
//==============================
// Cartridge loading front end, host download port in, header info,
// cheat codes and WRAM fill writes out
//==============================

module cart_loader (
	input  logic                                     clk_sys,
	input  logic                                     RESET,
	input  logic                                     ioctl_download,
	input  logic [7:0]                               ioctl_index,
	input  logic                                     ioctl_wr,
	input  logic [cart_loader_pkg::IO_ADDR_BITS-1:0]   ioctl_addr,
	input  logic [cart_loader_pkg::IO_DATA_BITS-1:0]   ioctl_dout,
	input  logic [2:0]                               hdr_mode,
	input  logic [1:0]                               region_sel,
	input  logic [1:0]                               wram_init,
	output logic [7:0]                               rom_type,
	output logic [cart_loader_pkg::MASK_BITS-1:0]      rom_mask,
	output logic [cart_loader_pkg::MASK_BITS-1:0]      ram_mask,
	output logic                                     pal,
	output logic [cart_loader_pkg::CODE_BITS-1:0]      code,
	output logic                                     code_valid,
	output logic [cart_loader_pkg::FILL_ADDR_BITS-1:0] fill_addr,
	output logic [7:0]                               fill_data,
	output logic                                     fill_wr,
	output logic                                     clearing
);
	import cart_loader_pkg::*;

	// Registered download port
	logic [IO_ADDR_BITS-1:0] dl_addr;
	logic [IO_DATA_BITS-1:0] dl_data;
	logic cart_wr;
	logic code_wr;
	logic cart_active;
	logic cart_start;

	download_decoder u_decoder (
		.clk_sys, .RESET,
		.ioctl_download, .ioctl_index, .ioctl_wr, .ioctl_addr, .ioctl_dout,
		.dl_addr, .dl_data, .cart_wr, .code_wr, .cart_active, .cart_start
	);

	header_parser u_header (
		.clk_sys, .RESET,
		.cart_wr, .cart_active, .dl_addr, .dl_data,
		.hdr_mode, .region_sel,
		.rom_type, .rom_mask, .ram_mask, .pal
	);

	cheat_assembler u_cheat (
		.clk_sys, .RESET,
		.code_wr, .dl_addr, .dl_data,
		.code, .code_valid
	);

	ram_clearer u_clear (
		.clk_sys, .RESET,
		.cart_start, .wram_init,
		.fill_addr, .fill_data, .fill_wr, .clearing
	);

endmodule

// File: src/ram_clearer.sv
//==============================
// Sweeps all WRAM addresses once per cartridge start, one write per cycle
// A new start during a sweep restarts it at address 0
//==============================

module ram_clearer (
	input  logic                                    clk_sys,
	input  logic                                    RESET,
	input  logic                                    cart_start,
	input  logic [1:0]                              wram_init,
	output logic [cart_loader_pkg::FILL_ADDR_BITS-1:0] fill_addr,
	output logic [7:0]                              fill_data,
	output logic                                    fill_wr,
	output logic                                    clearing
);

	//==============================
	// Sweep counter
	//==============================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			clearing  <= 1'b0;
			fill_addr <= '0;
		end else if (cart_start) begin
			clearing  <= 1'b1;
			fill_addr <= '0;
		end else if (clearing) begin
			// Wraps back to 0 after the last address
			fill_addr <= fill_addr + 1'b1;
			if (&fill_addr)
				clearing <= 1'b0;
		end
	end

	assign fill_wr = clearing;

	//==============================
	// Power-on fill pattern
	//==============================
	always_comb begin
		case (wram_init)
			2'd0:    fill_data = (fill_addr[8] ^ fill_addr[2]) ? 8'h66 : 8'h99;
			2'd1:    fill_data = (fill_addr[9] ^ fill_addr[0]) ? 8'hFF : 8'h00;
			2'd2:    fill_data = 8'h55;
			default: fill_data = 8'hFF;
		endcase
	end

endmodule

// File: src/cheat_assembler.sv
//==============================
// Builds one 128-bit cheat code from eight 16-bit words
// Only even offsets 0 to 14 of dl_addr[3:0] are decoded
//==============================

module cheat_assembler (
	input  logic                                   clk_sys,
	input  logic                                   RESET,
	input  logic                                   code_wr,
	input  logic [cart_loader_pkg::IO_ADDR_BITS-1:0] dl_addr,
	input  logic [cart_loader_pkg::IO_DATA_BITS-1:0] dl_data,
	output logic [cart_loader_pkg::CODE_BITS-1:0]  code,
	output logic                                   code_valid
);

	// Layout is flags, address, compare, replace from the top down
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (dl_addr[3:0])
				4'd0:  code[111:96]  <= dl_data;
				4'd2:  code[127:112] <= dl_data;
				4'd4:  code[79:64]   <= dl_data;
				4'd6:  code[95:80]   <= dl_data;
				4'd8:  code[47:32]   <= dl_data;
				4'd10: code[63:48]   <= dl_data;
				4'd12: code[15:0]    <= dl_data;
				4'd14: code[31:16]   <= dl_data;
				default: ;
			endcase
		end
	end

	// Last word completes the code
	always_ff @(posedge clk_sys) begin
		if (RESET)
			code_valid <= 1'b0;
		else
			code_valid <= code_wr && (dl_addr[3:0] == 4'd14);
	end

endmodule

// File: src/header_parser.sv
//==============================
// Decodes cartridge type, ROM/RAM masks and region from the image header
// Region output only tracks its source while no cartridge download runs
//==============================

module header_parser (
	input  logic                                   clk_sys,
	input  logic                                   RESET,
	input  logic                                   cart_wr,
	input  logic                                   cart_active,
	input  logic [cart_loader_pkg::IO_ADDR_BITS-1:0] dl_addr,
	input  logic [cart_loader_pkg::IO_DATA_BITS-1:0] dl_data,
	input  logic [2:0]                             hdr_mode,
	input  logic [1:0]                             region_sel,
	output logic [7:0]                             rom_type,
	output logic [cart_loader_pkg::MASK_BITS-1:0]  rom_mask,
	output logic [cart_loader_pkg::MASK_BITS-1:0]  ram_mask,
	output logic                                   pal
);
	import cart_loader_pkg::*;

	header_word_u hw;
	logic [3:0] rom_size;
	logic [3:0] ram_size;
	logic rom_region;

	logic [7:0] type_sel;
	logic int_en;
	logic [IO_ADDR_BITS-1:0] int_addr;

	assign hw = dl_data;

	// Type by header mode, auto mode takes it from the copier header
	always_comb begin
		case (hdr_mode)
			HDR_AUTO:    type_sel = hw.copier.cart_type;
			HDR_NONE:    type_sel = 8'd0;
			HDR_LOROM:   type_sel = 8'd0;
			HDR_HIROM:   type_sel = 8'd1;
			HDR_EXHIROM: type_sel = 8'd2;
			default:     type_sel = 8'd0;
		endcase
	end

	// Internal header location for the fixed modes
	always_comb begin
		int_en   = 1'b1;
		int_addr = LOROM_HDR;
		case (hdr_mode)
			HDR_LOROM:   int_addr = LOROM_HDR;
			HDR_HIROM:   int_addr = HIROM_HDR;
			HDR_EXHIROM: int_addr = EXHIROM_HDR;
			default:     int_en   = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_type   <= 8'd0;
			rom_size   <= DEFAULT_ROM_SIZE;
			ram_size   <= 4'd0;
			rom_region <= 1'b0;
			pal        <= 1'b0;
		end else begin
			if (cart_wr) begin
				// First word restarts from the defaults
				if (dl_addr == '0) begin
					rom_type <= type_sel;
					rom_size <= DEFAULT_ROM_SIZE;
					ram_size <= 4'd0;
					if (hdr_mode == HDR_AUTO &&
					    {hw.copier.ram_size, hw.copier.rom_size} != 8'd0) begin
						rom_size <= hw.copier.rom_size;
						ram_size <= hw.copier.ram_size;
					end
				end
				if (dl_addr == IO_ADDR_BITS'(2))
					rom_region <= dl_data[8];
				if (int_en && dl_addr == int_addr)
					rom_size <= hw.internal.rom_size;
				if (int_en && dl_addr == int_addr + IO_ADDR_BITS'(HDR_SIZE_OFF))
					ram_size <= hw.internal.ram_size;
			end
			// Held during a download
			if (!cart_active)
				pal <= (region_sel == REG_AUTO) ? rom_region : region_sel[1];
		end
	end

	// Masks follow the size registers directly
	assign rom_mask = (MASK_BITS'(MASK_UNIT) << rom_size) - 1'b1;
	assign ram_mask = (ram_size == 4'd0) ? '0 : (MASK_BITS'(MASK_UNIT) << ram_size) - 1'b1;

endmodule

// File: src/download_decoder.sv
//==============================
// Registers the host download port, one cycle of latency on every output
// Cartridge and cheat strobes are only valid while the download level is high
//==============================

module download_decoder (
	input  logic                                   clk_sys,
	input  logic                                   RESET,
	input  logic                                   ioctl_download,
	input  logic [7:0]                             ioctl_index,
	input  logic                                   ioctl_wr,
	input  logic [cart_loader_pkg::IO_ADDR_BITS-1:0] ioctl_addr,
	input  logic [cart_loader_pkg::IO_DATA_BITS-1:0] ioctl_dout,
	output logic [cart_loader_pkg::IO_ADDR_BITS-1:0] dl_addr,
	output logic [cart_loader_pkg::IO_DATA_BITS-1:0] dl_data,
	output logic                                   cart_wr,
	output logic                                   code_wr,
	output logic                                   cart_active,
	output logic                                   cart_start
);
	import cart_loader_pkg::*;

	logic cart_dl;
	logic code_dl;

	// Download kind from the index byte
	assign cart_dl = ioctl_download && (ioctl_index[5:0] == IDX_CART);
	assign code_dl = ioctl_download && (ioctl_index == IDX_CODE);

	// Payload path
	always_ff @(posedge clk_sys) begin
		dl_addr <= ioctl_addr;
		dl_data <= ioctl_dout;
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_wr     <= 1'b0;
			code_wr     <= 1'b0;
			cart_active <= 1'b0;
			cart_start  <= 1'b0;
		end else begin
			cart_wr     <= cart_dl && ioctl_wr;
			code_wr     <= code_dl && ioctl_wr;
			cart_active <= cart_dl;
			// cart_active still holds the previous level here
			cart_start  <= cart_dl && !cart_active;
		end
	end

endmodule

// File: src/cart_loader_pkg.sv
//==============================
// Shared constants and the header word view for the cartridge loader
// Header addresses include the 512-byte copier header
//==============================

package cart_loader_pkg;

	//==============================
	// Widths
	//==============================
	localparam int IO_ADDR_BITS   = 25;
	localparam int IO_DATA_BITS   = 16;
	localparam int MASK_BITS      = 24;
	localparam int CODE_BITS      = 128;
	localparam int FILL_ADDR_BITS = 17;

	//==============================
	// Index codes and header layout
	//==============================
	// Cartridge index is matched on its low six bits only
	localparam logic [5:0] IDX_CART = 6'd0;
	localparam logic [7:0] IDX_CODE = 8'hFF;

	localparam int COPIER_BYTES = 512;

	// Size byte of the internal header, RAM size word follows 2 bytes later
	localparam logic [IO_ADDR_BITS-1:0] LOROM_HDR   = IO_ADDR_BITS'('h7FD6 + COPIER_BYTES);
	localparam logic [IO_ADDR_BITS-1:0] HIROM_HDR   = IO_ADDR_BITS'('hFFD6 + COPIER_BYTES);
	localparam logic [IO_ADDR_BITS-1:0] EXHIROM_HDR = IO_ADDR_BITS'('h40FFD6 + COPIER_BYTES);
	localparam int HDR_SIZE_OFF = 2;

	localparam logic [3:0] DEFAULT_ROM_SIZE = 4'd12;
	// Bytes covered by size code 0
	localparam int MASK_UNIT = 1024;

	//==============================
	// Header modes and region select
	//==============================
	localparam logic [2:0] HDR_AUTO    = 3'd0;
	localparam logic [2:0] HDR_NONE    = 3'd1;
	localparam logic [2:0] HDR_LOROM   = 3'd2;
	localparam logic [2:0] HDR_HIROM   = 3'd3;
	localparam logic [2:0] HDR_EXHIROM = 3'd4;

	// Code 3 behaves as PAL
	localparam logic [1:0] REG_AUTO = 2'd0;
	localparam logic [1:0] REG_NTSC = 2'd1;
	localparam logic [1:0] REG_PAL  = 2'd2;

	// One download word, seen as copier header or as internal header
	typedef union packed {
		struct packed {
			logic [7:0] cart_type;
			logic [3:0] ram_size;
			logic [3:0] rom_size;
		} copier;
		struct packed {
			logic [3:0] rsvd_hi;
			logic [3:0] rom_size;
			logic [3:0] rsvd_lo;
			logic [3:0] ram_size;
		} internal;
	} header_word_u;

endpackage
